// File: rtl/bp_pkg.sv
// branch prediction front end package with widths, table sizes, index helpers and APB map
`default_nettype none

package bp_pkg;

  // addresses and fetch stepping
  typedef logic [31:0] pc_t;                     // instruction address
  localparam pc_t pc_step  = 32'd4;              // fall-through increment
  localparam pc_t reset_pc = 32'd0;              // fetch starts here

  // branch target buffer, direct mapped
  localparam int btb_entries = 16;
  typedef logic [3:0]  btb_index_t;              // pc[5:2]
  typedef logic [25:0] btb_tag_t;                // pc[31:6]

  // gshare
  localparam int ghr_bits = 6;
  typedef logic [ghr_bits-1:0] ghr_t;            // global history, newest in bit 0
  typedef logic [5:0] pht_index_t;               // pc[7:2] xor history
  localparam int pht_entries = 2 ** $bits(pht_index_t);
  typedef logic [1:0] counter_t;                 // saturating 2-bit counter
  localparam counter_t counter_reset = 2'd1;     // weakly not taken

  // fetch queue
  localparam int queue_depth = 4;
  typedef logic [2:0] queue_count_t;             // 0..queue_depth

  // APB side
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;
  localparam apb_addr_t addr_head_pc     = 8'h00; // ro
  localparam apb_addr_t addr_head_pred   = 8'h04; // ro
  localparam apb_addr_t addr_resolve     = 8'h08; // wo, real next pc of head
  localparam apb_addr_t addr_mispredicts = 8'h0C; // ro
  localparam apb_addr_t addr_status      = 8'h10; // ro, {count, not empty}

  typedef enum logic {idle, access} resolver_state_t;

  function automatic btb_index_t btb_index(pc_t pc);
    return pc[5:2];                              // word aligned, drop byte offset
  endfunction

  function automatic btb_tag_t btb_tag(pc_t pc);
    return pc[31:6];
  endfunction

  function automatic pht_index_t pht_index(pc_t pc, ghr_t ghr);
    return pht_index_t'(pc[7:2]) ^ ghr;          // gshare hash
  endfunction

endpackage

`default_nettype wire

// File: rtl/btb.sv
// direct-mapped branch target buffer, combinational lookup and one write port
`timescale 1ns/100ps
`default_nettype none

module btb (
  input  logic        clk,
  input  logic        reset,
  input  bp_pkg::pc_t lookup_pc,
  output logic        hit,
  output bp_pkg::pc_t target,
  input  logic        write,
  input  bp_pkg::pc_t write_pc,
  input  bp_pkg::pc_t write_target
);
  import bp_pkg::*;

  logic [btb_entries-1:0] valid;                 // cleared on reset
  btb_tag_t               tags    [btb_entries];
  pc_t                    targets [btb_entries];

  btb_index_t lookup_index;
  btb_index_t write_index;

  assign lookup_index = btb_index(lookup_pc);
  assign write_index  = btb_index(write_pc);

  // hit needs a live entry with the same upper pc bits
  assign hit    = valid[lookup_index] && (tags[lookup_index] == btb_tag(lookup_pc));
  assign target = targets[lookup_index];         // only meaningful on hit

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (write) begin
      valid[write_index] <= 1'b1;
    end
  end

  // tag and target storage
  always_ff @(posedge clk) begin
    if (write) begin
      tags[write_index]    <= btb_tag(write_pc);
      targets[write_index] <= write_target;      // overwrites any alias
    end
  end

endmodule

`default_nettype wire

// File: rtl/gshare_pht.sv
// gshare pattern history table of 2-bit counters with the global history register
`timescale 1ns/100ps
`default_nettype none

module gshare_pht (
  input  logic        clk,
  input  logic        reset,
  input  bp_pkg::pc_t lookup_pc,
  output logic        predict_taken,
  input  logic        train,
  input  bp_pkg::pc_t train_pc,
  input  logic        train_taken
);
  import bp_pkg::*;

  counter_t   pht [pht_entries];
  ghr_t       ghr;
  pht_index_t lookup_index;
  pht_index_t train_index;
  counter_t   train_count;

  // history only moves on training, so both sides see the same ghr
  assign lookup_index  = pht_index(lookup_pc, ghr);
  assign train_index   = pht_index(train_pc, ghr);
  assign predict_taken = pht[lookup_index][1];   // 2 or 3 means taken
  assign train_count   = pht[train_index];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < pht_entries; i++) begin
        pht[i] <= counter_reset;
      end
      ghr <= '0;
    end else if (train) begin
      if (train_taken && (train_count != '1)) begin
        pht[train_index] <= train_count + 2'd1;  // step up and saturate at 3
      end else if (!train_taken && (train_count != '0)) begin
        pht[train_index] <= train_count - 2'd1;  // step down and saturate at 0
      end
      ghr <= {ghr[ghr_bits-2:0], train_taken};   // shift in outcome
    end
  end

  // a training pulse must carry a known pc and outcome
  assert property (@(posedge clk) disable iff (reset)
    train |-> !$isunknown({train_pc, train_taken}))
    else $error("pht trained with an unknown pc or outcome");

endmodule

`default_nettype wire

// File: rtl/fetch_predictor.sv
// fetch pc register and next pc prediction from the BTB and gshare table
`timescale 1ns/100ps
`default_nettype none

module fetch_predictor (
  input  logic        clk,
  input  logic        reset,
  input  logic        full,
  input  logic        redirect,
  input  bp_pkg::pc_t redirect_pc,
  input  bp_pkg::pc_t train_pc,
  input  logic        train_taken,
  output logic        push,
  output bp_pkg::pc_t push_pc,
  output bp_pkg::pc_t push_pred
);
  import bp_pkg::*;

  pc_t  pc;
  pc_t  pred_pc;
  pc_t  btb_target;
  logic btb_hit;
  logic pht_taken;
  logic btb_write;

  assign btb_write = redirect && train_taken;    // only taken outcomes get a target

  btb btb_i (
    .clk          (clk),
    .reset        (reset),
    .lookup_pc    (pc),
    .hit          (btb_hit),
    .target       (btb_target),
    .write        (btb_write),
    .write_pc     (train_pc),
    .write_target (redirect_pc)
  );

  gshare_pht pht_i (
    .clk           (clk),
    .reset         (reset),
    .lookup_pc     (pc),
    .predict_taken (pht_taken),
    .train         (redirect),                   // mispredicts only
    .train_pc      (train_pc),
    .train_taken   (train_taken)
  );

  // need both a known target and a taken vote
  assign pred_pc   = (btb_hit && pht_taken) ? btb_target : pc + pc_step;
  assign push      = !full && !redirect;         // redirect cycle drops the stale fetch
  assign push_pc   = pc;
  assign push_pred = pred_pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else if (redirect) begin
      pc <= redirect_pc;                         // resolver wins over prediction
    end else if (push) begin
      pc <= pred_pc;
    end                                          // full: pc holds
  end

endmodule

`default_nettype wire

// File: rtl/fetch_queue.sv
// in-order circular queue of fetched (pc, predicted next pc) pairs with flush
`timescale 1ns/100ps
`default_nettype none

module fetch_queue (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 push,
  input  bp_pkg::pc_t          push_pc,
  input  bp_pkg::pc_t          push_pred,
  input  logic                 pop,
  input  logic                 flush,
  output logic                 full,
  output logic                 head_valid,
  output bp_pkg::pc_t          head_pc,
  output bp_pkg::pc_t          head_pred,
  output bp_pkg::queue_count_t count
);
  import bp_pkg::*;

  localparam int ptr_bits = $clog2(queue_depth);

  pc_t                 pc_mem   [queue_depth];
  pc_t                 pred_mem [queue_depth];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;

  assign head_valid = count != '0;
  assign full       = count == queue_count_t'(queue_depth);
  assign head_pc    = pc_mem[rd_ptr];            // garbage when empty, resolver masks
  assign head_pred  = pred_mem[rd_ptr];

  // pointers and fill level, flush beats push and pop
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;                 // wraps at depth
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                 // none, or both at once
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      pc_mem[wr_ptr]   <= push_pc;
      pred_mem[wr_ptr] <= push_pred;
    end
  end

  // producer must respect full, resolver must respect head_valid
  assert property (@(posedge clk) disable iff (reset) full |-> !push)
    else $error("push into full fetch queue");
  assert property (@(posedge clk) disable iff (reset) !head_valid |-> !pop)
    else $error("pop from empty fetch queue");

endmodule

`default_nettype wire

// File: rtl/branch_resolver.sv
// APB slave that resolves the oldest fetch entry, redirects on mispredict and counts them
`timescale 1ns/100ps
`default_nettype none

module branch_resolver (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  bp_pkg::apb_addr_t    paddr,
  input  bp_pkg::apb_data_t    pwdata,
  output bp_pkg::apb_data_t    prdata,
  output logic                 pready,
  output logic                 pslverr,
  input  logic                 head_valid,
  input  bp_pkg::pc_t          head_pc,
  input  bp_pkg::pc_t          head_pred,
  input  bp_pkg::queue_count_t count,
  output logic                 pop,
  output logic                 redirect,
  output bp_pkg::pc_t          redirect_pc,
  output bp_pkg::pc_t          train_pc,
  output logic                 train_taken
);
  import bp_pkg::*;

  resolver_state_t state;
  apb_data_t       mispredicts;                  // since reset
  apb_data_t       read_data;
  logic            read_ok;                      // address is a readable register
  logic            access_phase;
  logic            is_resolve;
  logic            accept;
  logic            mispredict;
  pc_t             fall_through;

  assign access_phase = (state == access) && psel && penable;
  assign is_resolve   = paddr == addr_resolve;

  // head fields read 0 on an empty queue
  always_comb begin
    read_ok   = 1'b1;
    read_data = '0;
    case (paddr)
      addr_head_pc:     read_data = head_valid ? head_pc : '0;
      addr_head_pred:   read_data = head_valid ? head_pred : '0;
      addr_mispredicts: read_data = mispredicts;
      addr_status:      read_data = apb_data_t'({count, head_valid});
      default:          read_ok = 1'b0;          // includes resolve
    endcase
  end

  // resolve write stalls until there is something to resolve
  assign pready  = access_phase && !(pwrite && is_resolve && !head_valid);
  assign pslverr = access_phase && (pwrite ? !is_resolve : !read_ok);
  assign prdata  = (access_phase && !pwrite) ? read_data : '0;

  assign accept     = access_phase && pwrite && is_resolve && head_valid;
  assign mispredict = pwdata != head_pred;
  assign pop        = accept && !mispredict;     // prediction confirmed
  assign redirect   = accept && mispredict;      // flush and refetch

  assign redirect_pc  = pwdata;
  assign train_pc     = head_pc;
  assign fall_through = head_pc + pc_step;
  assign train_taken  = redirect_pc != fall_through; // anything but pc+4 is taken

  // setup to access tracking with one completion per transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (psel && !penable) begin
            state <= access;
          end
        end
        access: begin
          if (pready || !psel) begin
            state <= idle;                       // done or host abandoned
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mispredicts <= '0;
    end else if (redirect) begin
      mispredicts <= mispredicts + 1'b1;
    end
  end

  // a stalled transfer keeps its address, direction and data
  assert property (@(posedge clk) disable iff (reset)
    (access_phase && !pready) ##1 psel |->
      $stable(paddr) && $stable(pwrite) && $stable(pwdata))
    else $error("APB transfer changed while stalled");
  // the queue must be empty right after a redirect
  assert property (@(posedge clk) disable iff (reset) redirect |=> !head_valid)
    else $error("fetch queue not flushed by redirect");

endmodule

`default_nettype wire

// File: rtl/bp_frontend.sv
// branch prediction front end top, predictor feeding a fetch queue resolved over APB
`timescale 1ns/100ps
`default_nettype none

module bp_frontend (
  input  logic              clk,
  input  logic              reset,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  bp_pkg::apb_addr_t paddr,
  input  bp_pkg::apb_data_t pwdata,
  output bp_pkg::apb_data_t prdata,
  output logic              pready,
  output logic              pslverr
);
  import bp_pkg::*;

  logic         full;
  logic         push;
  pc_t          push_pc;
  pc_t          push_pred;
  logic         head_valid;
  pc_t          head_pc;
  pc_t          head_pred;
  queue_count_t count;
  logic         pop;
  logic         redirect;                        // also the queue flush
  pc_t          redirect_pc;
  pc_t          train_pc;
  logic         train_taken;

  fetch_predictor predictor_i (
    .clk         (clk),
    .reset       (reset),
    .full        (full),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .train_pc    (train_pc),
    .train_taken (train_taken),
    .push        (push),
    .push_pc     (push_pc),
    .push_pred   (push_pred)
  );

  fetch_queue queue_i (
    .clk        (clk),
    .reset      (reset),
    .push       (push),
    .push_pc    (push_pc),
    .push_pred  (push_pred),
    .pop        (pop),
    .flush      (redirect),
    .full       (full),
    .head_valid (head_valid),
    .head_pc    (head_pc),
    .head_pred  (head_pred),
    .count      (count)
  );

  branch_resolver resolver_i (
    .clk         (clk),
    .reset       (reset),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .head_valid  (head_valid),
    .head_pc     (head_pc),
    .head_pred   (head_pred),
    .count       (count),
    .pop         (pop),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .train_pc    (train_pc),
    .train_taken (train_taken)
  );

endmodule

`default_nettype wire

// File: tests/bp_frontend_tb.sv
// testbench driving the branch prediction front end over APB against a reference model
`timescale 1ns/100ps
`default_nettype none

module bp_frontend_tb;
  import bp_pkg::*;

  localparam int  max_transfers = 1100;           // bound over all five tests
  localparam int  settle_cycles = 200;            // reset plus idle waits
  localparam time watchdog_time = (max_transfers * 20 + 10 + settle_cycles) * 40;
  localparam int  pready_limit  = 50;             // cycles before a transfer counts as hung
  localparam int  random_steps  = 300;

  logic      clk;
  logic      reset;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  // reference model
  logic      m_valid  [btb_entries];
  btb_tag_t  m_tag    [btb_entries];
  pc_t       m_target [btb_entries];
  counter_t  m_pht    [pht_entries];
  ghr_t      m_ghr;
  pc_t       m_head;                              // pc expected at the queue head
  apb_data_t m_mispredicts;

  pc_t targets [8];                               // branch targets for the random run
  int  checks;
  int  errors;
  int  tests;
  int  test_errors;

  bp_frontend bp_frontend_i (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #20 clk = ~clk;                          // 40 ns period

  task automatic compare_pc(input string name, input pc_t got, input pc_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic compare_data(input string name, input apb_data_t got, input apb_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic compare_count(input string name, input queue_count_t got,
                               input queue_count_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, got);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s expected %b got %b", $time, name, exp, got);
    end
  endtask

  // one setup cycle and access cycles until pready
  task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
    int waits;
    waits = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);                               // outputs sampled on the falling edge
    while (!pready && waits < pready_limit) begin
      @(negedge clk);
      waits++;
    end
    if (!pready) begin
      errors++;
      $display("transfer to address %h never completed, pready stayed low", addr);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;                              // transfer ends on this edge
    penable <= 1'b0;
  endtask

  task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
    logic err;
    apb_transfer(1'b0, addr, '0, data, err);
    compare_flag("pslverr", err, 1'b0);
  endtask

  task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
    apb_data_t unused;
    logic      err;
    apb_transfer(1'b1, addr, data, unused, err);
    compare_flag("pslverr", err, 1'b0);
  endtask

  task automatic model_reset();
    for (int i = 0; i < btb_entries; i++) begin
      m_valid[i] = 1'b0;
    end
    for (int i = 0; i < pht_entries; i++) begin
      m_pht[i] = 2'd1;                            // weakly not taken
    end
    m_ghr         = '0;
    m_head        = '0;
    m_mispredicts = '0;
  endtask

  // taken only with a BTB hit and a counter of 2 or 3
  function automatic pc_t model_predict(input pc_t pc);
    logic [3:0] bi;
    logic [5:0] pi;
    logic       hit;
    bi  = pc[5:2];
    pi  = pc[7:2] ^ m_ghr;
    hit = m_valid[bi] && (m_tag[bi] == pc[31:6]);
    if (hit && (m_pht[pi] >= 2'd2)) begin
      return m_target[bi];
    end
    return pc + 32'd4;
  endfunction

  // train on a mispredict only and restart the queue at the real pc
  task automatic model_resolve(input pc_t real_pc);
    pc_t        pred;
    logic       taken;
    logic [3:0] bi;
    logic [5:0] pi;
    pred = model_predict(m_head);
    if (real_pc != pred) begin
      taken = real_pc != (m_head + 32'd4);
      bi    = m_head[5:2];
      pi    = m_head[7:2] ^ m_ghr;
      if (taken) begin
        m_valid[bi]  = 1'b1;
        m_tag[bi]    = m_head[31:6];
        m_target[bi] = real_pc;
      end
      if (taken && (m_pht[pi] != 2'd3)) begin
        m_pht[pi] = m_pht[pi] + 2'd1;
      end else if (!taken && (m_pht[pi] != 2'd0)) begin
        m_pht[pi] = m_pht[pi] - 2'd1;
      end
      m_ghr = {m_ghr[4:0], taken};
      m_mispredicts++;
    end
    m_head = real_pc;
  endtask

  // check the head against the model and resolve it
  task automatic resolve_step(input pc_t real_pc);
    apb_data_t data;
    read_reg(addr_head_pc, data);
    compare_pc("head_pc", pc_t'(data), m_head);
    read_reg(addr_head_pred, data);
    compare_pc("head_pred", pc_t'(data), model_predict(m_head));
    write_reg(addr_resolve, real_pc);
    model_resolve(real_pc);
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == test_errors) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin
    apb_data_t data;
    apb_data_t unused;
    logic      err;
    pc_t       real_pc;
    logic      learned;
    void'($urandom(97));
    clk         = 1'b0;
    reset       = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    checks      = 0;
    errors      = 0;
    tests       = 0;
    test_errors = 0;
    targets     = '{32'h000, 32'h010, 32'h040, 32'h050, 32'h0c0, 32'h100, 32'h110, 32'h140};
    model_reset();
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    repeat (8) @(posedge clk);                    // queue fills up

    read_reg(addr_status, data);
    compare_flag("status not empty", data[0], 1'b1);
    compare_count("status count", queue_count_t'(data[3:1]), queue_count_t'(queue_depth));
    read_reg(addr_head_pc, data);
    compare_pc("head_pc", pc_t'(data), 32'd0);
    read_reg(addr_head_pred, data);
    compare_pc("head_pred", pc_t'(data), 32'd4);
    for (int i = 0; i < 4; i++) begin
      resolve_step(m_head + 32'd4);               // 0, 4, 8, 12 fall through
    end
    read_reg(addr_mispredicts, data);
    compare_data("mispredicts", data, 32'd0);
    finish_test("sequential walk");

    resolve_step(32'd64);                         // head 16 jumps away
    read_reg(addr_head_pc, data);
    compare_pc("head_pc", pc_t'(data), 32'd64);
    read_reg(addr_mispredicts, data);
    compare_data("mispredicts", data, 32'd1);
    repeat (8) @(posedge clk);
    read_reg(addr_status, data);
    compare_count("status count", queue_count_t'(data[3:1]), queue_count_t'(queue_depth));
    finish_test("redirect");

    // loop 16 and 64 until history settles and pc 16 predicts its target
    learned = 1'b0;
    for (int i = 0; i < 20 && !learned; i++) begin
      if (m_head == 32'd16 && model_predict(m_head) == 32'd64) begin
        learned = 1'b1;
      end else begin
        resolve_step((m_head == 32'd16) ? 32'd64 : 32'd16);
      end
    end
    read_reg(addr_head_pred, data);
    compare_pc("head_pred", pc_t'(data), 32'd64);
    finish_test("learned branch");

    for (int i = 0; i < random_steps; i++) begin
      if ($urandom % 2) begin
        real_pc = m_head + 32'd4;
      end else begin
        real_pc = targets[$urandom % 8];          // aliases in BTB and PHT
      end
      resolve_step(real_pc);
      if (i % 25 == 24) begin
        read_reg(addr_mispredicts, data);
        compare_data("mispredicts", data, m_mispredicts);
      end
    end
    finish_test("random resolves");

    apb_transfer(1'b1, addr_head_pc, 32'h44, unused, err);
    compare_flag("pslverr write head_pc", err, 1'b1);
    apb_transfer(1'b0, addr_resolve, '0, unused, err);
    compare_flag("pslverr read resolve", err, 1'b1);
    apb_transfer(1'b0, 8'h20, '0, unused, err);
    compare_flag("pslverr read unmapped", err, 1'b1);
    apb_transfer(1'b1, 8'h20, 32'h80, unused, err);
    compare_flag("pslverr write unmapped", err, 1'b1);
    read_reg(addr_head_pc, data);
    compare_pc("head_pc", pc_t'(data), m_head);
    read_reg(addr_mispredicts, data);
    compare_data("mispredicts", data, m_mispredicts);
    finish_test("bus errors");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog sized from the transfer count
  initial begin
    #(watchdog_time);
    $display("watchdog expired, the run did not finish in time");
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: bp_frontend.f
rtl/bp_pkg.sv
rtl/btb.sv
rtl/gshare_pht.sv
rtl/fetch_predictor.sv
rtl/fetch_queue.sv
rtl/branch_resolver.sv
rtl/bp_frontend.sv
tests/bp_frontend_tb.sv

// File: Bender.yml
package:
  name: bp_frontend

sources:
  - files:
      - rtl/bp_pkg.sv
      - rtl/btb.sv
      - rtl/gshare_pht.sv
      - rtl/fetch_predictor.sv
      - rtl/fetch_queue.sv
      - rtl/branch_resolver.sv
      - rtl/bp_frontend.sv
  - target: test
    files:
      - tests/bp_frontend_tb.sv
